/* Bender.yml */
package:
  name: jtag_sniffer

sources:
  - include_dirs:
      - design
    files:
      - design/jtag_sniffer_pkg.sv
      - design/jtag_pin_sync.sv
      - design/tap_state_tracker.sv
      - design/bit_history_capture.sv
      - design/display_composer.sv
      - design/digit_scanner.sv
      - design/jtag_sniffer_top.sv
  - target: simulation
    files:
      - sim/tb_jtag_sniffer_top.sv

/* design/bit_history_capture.sv */
`timescale 1ns/10ps
`include "jtag_sniffer_macros.svh"

module bit_history_capture (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           sample_strobe,
    input  jtag_sniffer_pkg::jtag_sample_t sample,
    output logic [`JS_HIST_BITS-1:0]       tms_hist,
    output logic [`JS_HIST_BITS-1:0]       tdi_hist,
    output logic [`JS_HIST_BITS-1:0]       tdo_hist
);

    // newest bit enters at the msb so it shows leftmost on the display,
    // older bits drift toward bit 0 and fall off
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tms_hist <= '0;
            tdi_hist <= '0;
            tdo_hist <= '0;
        end else if (sample_strobe) begin
            tms_hist <= {sample.tms, tms_hist[`JS_HIST_BITS-1:1]};
            tdi_hist <= {sample.tdi, tdi_hist[`JS_HIST_BITS-1:1]};
            tdo_hist <= {sample.tdo, tdo_hist[`JS_HIST_BITS-1:1]};  // taken at the rise
        end
    end

endmodule

/* design/digit_scanner.sv */
`timescale 1ns/10ps
`include "jtag_sniffer_macros.svh"

module digit_scanner (
    input  logic                             clk,
    input  logic                             rst_n,
    input  jtag_sniffer_pkg::display_frame_t frame,
    output logic                             digit_valid,
    input  logic                             digit_ready,
    output jtag_sniffer_pkg::digit_beat_t    digit
);

    logic [$clog2(`JS_ROWS)-1:0]      row_q;   // position of the next beat to load
    logic [$clog2(`JS_DIGITS)-1:0]    col_q;
    jtag_sniffer_pkg::display_frame_t snap_q;  // frame copy for a whole pass
    logic                             load;
    logic                             frame_start;
    logic [3:0]                       nibble;

    assign load        = ~digit_valid | digit_ready;  // empty, or current beat leaves
    assign frame_start = (row_q == '0) && (col_q == '1);

    // first digit comes straight from the live frame, the rest from the copy
    assign nibble = frame_start ? frame[0].digit[`JS_DIGITS-1]
                                : snap_q[row_q].digit[col_q];

    // position counters and valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            digit_valid <= 1'b0;
            row_q       <= '0;
            col_q       <= '1;  // start at row 0 col 15
        end else if (load) begin
            digit_valid <= 1'b1;
            col_q       <= col_q - 1'b1;  // 0 wraps to 15
            if (col_q == '0) begin
                row_q <= row_q + 1'b1;  // row 3 wraps to row 0
            end
        end
    end

    // beat and snapshot, held steady while the sink stalls
    always_ff @(posedge clk) begin
        if (load) begin
            digit.row    <= row_q;
            digit.col    <= col_q;
            digit.nibble <= nibble;
            if (frame_start) begin
                snap_q <= frame;
            end
        end
    end

endmodule

/* design/display_composer.sv */
`timescale 1ns/10ps
`include "jtag_sniffer_macros.svh"

module display_composer (
    input  logic                             clk,
    input  logic                             rst_n,
    input  jtag_sniffer_pkg::tap_state_e     tap_state,
    input  logic [15:0]                      edge_count,
    input  logic [`JS_HIST_BITS-1:0]         tms_hist,
    input  logic [`JS_HIST_BITS-1:0]         tdi_hist,
    input  logic [`JS_HIST_BITS-1:0]         tdo_hist,
    output jtag_sniffer_pkg::display_frame_t frame
);

    jtag_sniffer_pkg::display_frame_t frame_next;

    always_comb begin
        frame_next = '0;
        // row 0 status line: state leftmost, edge count rightmost
        frame_next[0].digit[`JS_DIGITS-1] = tap_state;
        frame_next[0].digit[3:0]          = edge_count;
        // history rows taken bit for bit
        frame_next[1].bits = tms_hist;
        frame_next[2].bits = tdi_hist;
        frame_next[3].bits = tdo_hist;
    end

    // registered so the scanner never samples a half updated word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame                       <= '0;
            frame[0].digit[`JS_DIGITS-1] <= jtag_sniffer_pkg::test_logic_reset;
        end else begin
            frame <= frame_next;
        end
    end

endmodule

/* design/jtag_pin_sync.sv */
`timescale 1ns/10ps
`include "jtag_sniffer_macros.svh"

module jtag_pin_sync (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           tck,
    input  logic                           tms,
    input  logic                           tdi,
    input  logic                           tdo,
    output logic                           sample_strobe,
    output jtag_sniffer_pkg::jtag_sample_t sample
);

    // pin order in every stage is tck, tms, tdi, tdo
    logic [`JS_SYNC_STAGES-1:0][3:0] sync_q;  // stage 0 sees the raw pins
    logic [3:0] pins_q;    // settled levels, one flop past the chain
    logic       tck_prev;  // tck from pins_q one cycle earlier
    logic       tck_rise;

    assign tck_rise = pins_q[3] & ~tck_prev;  // low then high

    // synchronizer and edge history keep running through reset
    // so a high tck at reset release is not taken as a rise
    always_ff @(posedge clk) begin
        sync_q   <= {sync_q[`JS_SYNC_STAGES-2:0], {tck, tms, tdi, tdo}};
        pins_q   <= sync_q[`JS_SYNC_STAGES-1];
        tck_prev <= pins_q[3];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sample_strobe <= 1'b0;
        end else begin
            sample_strobe <= tck_rise;  // one cycle per rise
        end
    end

    // levels ride along with the strobe
    always_ff @(posedge clk) begin
        sample.tms <= pins_q[2];
        sample.tdi <= pins_q[1];
        sample.tdo <= pins_q[0];
    end

endmodule

/* design/jtag_sniffer_macros.svh */
`ifndef JTAG_SNIFFER_MACROS_SVH
`define JTAG_SNIFFER_MACROS_SVH

// bits of history kept per jtag wire, one display row worth
`define JS_HIST_BITS 64

// display geometry
`define JS_ROWS 4     // row 0 status, rows 1..3 tms/tdi/tdo
`define JS_DIGITS 16  // hex digits per row

// flops per pin in the input synchronizer
`define JS_SYNC_STAGES 2

`endif

/* design/jtag_sniffer_pkg.sv */
`include "jtag_sniffer_macros.svh"

package jtag_sniffer_pkg;

    // pin levels captured at one tck rise
    typedef struct packed {
        logic tms;
        logic tdi;
        logic tdo;  // target output, stable at the rise
    } jtag_sample_t;

    // 1149.1 tap states, codes as commonly shown in debuggers
    typedef enum logic [3:0] {
        test_logic_reset = 4'hF,
        run_test_idle    = 4'hC,
        select_dr        = 4'h7,
        capture_dr       = 4'h6,
        shift_dr         = 4'h2,
        exit1_dr         = 4'h1,
        pause_dr         = 4'h3,
        exit2_dr         = 4'h0,
        update_dr        = 4'h5,
        select_ir        = 4'h4,
        capture_ir       = 4'hE,
        shift_ir         = 4'hA,
        exit1_ir         = 4'h9,
        pause_ir         = 4'hB,
        exit2_ir         = 4'h8,
        update_ir        = 4'hD
    } tap_state_e;

    // one display row, written as raw bits or as hex digits
    typedef union packed {
        logic [`JS_HIST_BITS-1:0]   bits;
        logic [`JS_DIGITS-1:0][3:0] digit;  // digit 15 is leftmost
    } display_row_u;

    typedef display_row_u [`JS_ROWS-1:0] display_frame_t;  // index 0 is row 0

    // one hex digit on the output stream
    typedef struct packed {
        logic [$clog2(`JS_ROWS)-1:0]   row;
        logic [$clog2(`JS_DIGITS)-1:0] col;
        logic [3:0]                    nibble;
    } digit_beat_t;

endpackage

/* design/jtag_sniffer_top.sv */
`timescale 1ns/10ps
`include "jtag_sniffer_macros.svh"

module jtag_sniffer_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          tck,
    input  logic                          tms,
    input  logic                          tdi,
    input  logic                          tdo,
    output logic                          digit_valid,
    input  logic                          digit_ready,
    output jtag_sniffer_pkg::digit_beat_t digit
);

    logic                             sample_strobe;
    jtag_sniffer_pkg::jtag_sample_t   sample;
    jtag_sniffer_pkg::tap_state_e     tap_state;
    logic [15:0]                      edge_count;
    logic [`JS_HIST_BITS-1:0]         tms_hist;
    logic [`JS_HIST_BITS-1:0]         tdi_hist;
    logic [`JS_HIST_BITS-1:0]         tdo_hist;
    jtag_sniffer_pkg::display_frame_t frame;

    // pins in, one strobe per tck rise
    jtag_pin_sync jtag_pin_sync_i (
        .clk(clk), .rst_n(rst_n),
        .tck(tck), .tms(tms), .tdi(tdi), .tdo(tdo),
        .sample_strobe(sample_strobe), .sample(sample)
    );

    // tracker and capture see the same strobe
    tap_state_tracker tap_state_tracker_i (
        .clk(clk), .rst_n(rst_n),
        .sample_strobe(sample_strobe), .sample(sample),
        .tap_state(tap_state), .edge_count(edge_count)
    );

    bit_history_capture bit_history_capture_i (
        .clk(clk), .rst_n(rst_n),
        .sample_strobe(sample_strobe), .sample(sample),
        .tms_hist(tms_hist), .tdi_hist(tdi_hist), .tdo_hist(tdo_hist)
    );

    display_composer display_composer_i (
        .clk(clk), .rst_n(rst_n),
        .tap_state(tap_state), .edge_count(edge_count),
        .tms_hist(tms_hist), .tdi_hist(tdi_hist), .tdo_hist(tdo_hist),
        .frame(frame)
    );

    // frame out as a digit stream
    digit_scanner digit_scanner_i (
        .clk(clk), .rst_n(rst_n),
        .frame(frame),
        .digit_valid(digit_valid), .digit_ready(digit_ready), .digit(digit)
    );

endmodule

/* design/tap_state_tracker.sv */
`timescale 1ns/10ps

module tap_state_tracker (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           sample_strobe,
    input  jtag_sniffer_pkg::jtag_sample_t sample,
    output jtag_sniffer_pkg::tap_state_e   tap_state,
    output logic [15:0]                    edge_count
);

    jtag_sniffer_pkg::tap_state_e tap_next;

    // standard tap transition table, split on tms
    always_comb begin
        tap_next = tap_state;
        if (sample.tms) begin
            case (tap_state)
                jtag_sniffer_pkg::test_logic_reset: tap_next = jtag_sniffer_pkg::test_logic_reset;
                jtag_sniffer_pkg::run_test_idle:    tap_next = jtag_sniffer_pkg::select_dr;
                jtag_sniffer_pkg::select_dr:        tap_next = jtag_sniffer_pkg::select_ir;
                jtag_sniffer_pkg::capture_dr:       tap_next = jtag_sniffer_pkg::exit1_dr;
                jtag_sniffer_pkg::shift_dr:         tap_next = jtag_sniffer_pkg::exit1_dr;
                jtag_sniffer_pkg::exit1_dr:         tap_next = jtag_sniffer_pkg::update_dr;
                jtag_sniffer_pkg::pause_dr:         tap_next = jtag_sniffer_pkg::exit2_dr;
                jtag_sniffer_pkg::exit2_dr:         tap_next = jtag_sniffer_pkg::update_dr;
                jtag_sniffer_pkg::update_dr:        tap_next = jtag_sniffer_pkg::select_dr;
                jtag_sniffer_pkg::select_ir:        tap_next = jtag_sniffer_pkg::test_logic_reset;
                jtag_sniffer_pkg::capture_ir:       tap_next = jtag_sniffer_pkg::exit1_ir;
                jtag_sniffer_pkg::shift_ir:         tap_next = jtag_sniffer_pkg::exit1_ir;
                jtag_sniffer_pkg::exit1_ir:         tap_next = jtag_sniffer_pkg::update_ir;
                jtag_sniffer_pkg::pause_ir:         tap_next = jtag_sniffer_pkg::exit2_ir;
                jtag_sniffer_pkg::exit2_ir:         tap_next = jtag_sniffer_pkg::update_ir;
                jtag_sniffer_pkg::update_ir:        tap_next = jtag_sniffer_pkg::select_dr;
                default:                            tap_next = jtag_sniffer_pkg::test_logic_reset;
            endcase
        end else begin
            case (tap_state)
                jtag_sniffer_pkg::test_logic_reset: tap_next = jtag_sniffer_pkg::run_test_idle;
                jtag_sniffer_pkg::run_test_idle:    tap_next = jtag_sniffer_pkg::run_test_idle;
                jtag_sniffer_pkg::select_dr:        tap_next = jtag_sniffer_pkg::capture_dr;
                jtag_sniffer_pkg::capture_dr:       tap_next = jtag_sniffer_pkg::shift_dr;
                jtag_sniffer_pkg::shift_dr:         tap_next = jtag_sniffer_pkg::shift_dr;
                jtag_sniffer_pkg::exit1_dr:         tap_next = jtag_sniffer_pkg::pause_dr;
                jtag_sniffer_pkg::pause_dr:         tap_next = jtag_sniffer_pkg::pause_dr;
                jtag_sniffer_pkg::exit2_dr:         tap_next = jtag_sniffer_pkg::shift_dr;
                jtag_sniffer_pkg::update_dr:        tap_next = jtag_sniffer_pkg::run_test_idle;
                jtag_sniffer_pkg::select_ir:        tap_next = jtag_sniffer_pkg::capture_ir;
                jtag_sniffer_pkg::capture_ir:       tap_next = jtag_sniffer_pkg::shift_ir;
                jtag_sniffer_pkg::shift_ir:         tap_next = jtag_sniffer_pkg::shift_ir;
                jtag_sniffer_pkg::exit1_ir:         tap_next = jtag_sniffer_pkg::pause_ir;
                jtag_sniffer_pkg::pause_ir:         tap_next = jtag_sniffer_pkg::pause_ir;
                jtag_sniffer_pkg::exit2_ir:         tap_next = jtag_sniffer_pkg::shift_ir;
                jtag_sniffer_pkg::update_ir:        tap_next = jtag_sniffer_pkg::run_test_idle;
                default:                            tap_next = jtag_sniffer_pkg::test_logic_reset;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tap_state  <= jtag_sniffer_pkg::test_logic_reset;  // same as a target after trst
            edge_count <= '0;
        end else if (sample_strobe) begin
            tap_state  <= tap_next;
            edge_count <= edge_count + 16'd1;  // wraps at 65536
        end
    end

endmodule

/* sim.f */
+incdir+design
design/jtag_sniffer_pkg.sv
design/jtag_pin_sync.sv
design/tap_state_tracker.sv
design/bit_history_capture.sv
design/display_composer.sv
design/digit_scanner.sv
design/jtag_sniffer_top.sv
sim/tb_jtag_sniffer_top.sv

/* sim/tb_jtag_sniffer_top.sv */
`timescale 1ns/10ps

module tb_jtag_sniffer_top;

    // nibble n of each table holds the 1149.1 successor of state code n
    localparam logic [63:0] next_on_one  = 64'hF977_89DD_417F_0155;
    localparam logic [63:0] next_on_zero = 64'hCACC_BABA_62CE_3232;
    localparam int tck_periods = 200 + 9 + 100 + 60;
    localparam int frame_checks = 5;
    // 16 clk per tck period plus back-pressure and idle per check, all doubled
    localparam int timeout_cycles = 2 * (16 * tck_periods + frame_checks * (4 * 64 * 4 + 20));

    logic clk = 1'b0;
    logic rst_n;
    logic tck;
    logic tms;
    logic tdi;
    logic tdo;
    logic digit_valid;
    logic digit_ready;
    jtag_sniffer_pkg::digit_beat_t digit;

    jtag_sniffer_pkg::tap_state_e  model_state;
    logic [15:0]                   model_count;
    logic [63:0]                   model_tms;
    logic [63:0]                   model_tdi;
    logic [63:0]                   model_tdo;
    jtag_sniffer_pkg::digit_beat_t beat_q[$];  // transfers seen by the monitor
    jtag_sniffer_pkg::digit_beat_t held_beat;
    logic                          stalled;
    logic [1:0]                    exp_row;    // position the next transfer must carry
    logic [3:0]                    exp_col;
    logic [3:0]                    shown_state;
    int                            value_errors = 0;
    int                            handshake_errors = 0;
    int                            cycle_count = 0;

    jtag_sniffer_top jtag_sniffer_top_i (
        .clk(clk), .rst_n(rst_n),
        .tck(tck), .tms(tms), .tdi(tdi), .tdo(tdo),
        .digit_valid(digit_valid), .digit_ready(digit_ready), .digit(digit)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run went past %0d cycles without finishing", timeout_cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // handshake monitor samples at the falling edge where everything is stable
    always @(negedge clk) begin
        if (!rst_n) begin
            exp_row = 2'd0;
            exp_col = 4'd15;  // first beat after reset
            stalled = 1'b0;
        end else begin
            if (stalled && (!digit_valid || digit != held_beat)) begin
                handshake_errors++;
                $display("digit_valid dropped or digit changed while digit_ready was low at %0t",
                         $time);
            end
            if (digit_valid && digit_ready) begin
                if (digit.row != exp_row || digit.col != exp_col) begin
                    handshake_errors++;
                    $display("beat order broken, wanted row %0d col %0d but got row %0d col %0d",
                             exp_row, exp_col, digit.row, digit.col);
                end
                beat_q.push_back(digit);
                exp_row = (digit.col == 4'd0) ? digit.row + 2'd1 : digit.row;
                exp_col = digit.col - 4'd1;  // resync on the actual beat
            end
            stalled   = digit_valid && !digit_ready;
            held_beat = digit;
        end
    end

    // one clock step with a fresh random ready for the sink
    task automatic next_cycle();
        @(posedge clk);
        #1;
        digit_ready = ($urandom_range(1, 0) == 1);  // sink accepts about every other cycle
    endtask

    task automatic model_reset();
        model_state = jtag_sniffer_pkg::test_logic_reset;
        model_count = '0;
        model_tms   = '0;
        model_tdi   = '0;
        model_tdo   = '0;
    endtask

    // what a target sees at the tck rise
    task automatic model_rise(input logic m, input logic i, input logic o);
        logic [3:0] code;
        code        = model_state;
        model_state = jtag_sniffer_pkg::tap_state_e'(m ? next_on_one[4 * code +: 4]
                                                       : next_on_zero[4 * code +: 4]);
        model_count = model_count + 16'd1;
        model_tms   = {m, model_tms[63:1]};  // newest at the msb
        model_tdi   = {i, model_tdi[63:1]};
        model_tdo   = {o, model_tdo[63:1]};
    endtask

    // one tck period with the pins moving mid low phase
    task automatic tck_period(input logic m, input logic i, input logic o);
        tck = 1'b0;
        repeat (4) next_cycle();
        tms = m;
        tdi = i;
        tdo = o;
        repeat (4) next_cycle();
        tck = 1'b1;
        model_rise(m, i, o);
        repeat (8) next_cycle();
    endtask

    task automatic random_traffic(input int periods);
        repeat (periods) begin
            tck_period($urandom_range(1, 0) == 1, $urandom_range(1, 0) == 1,
                       $urandom_range(1, 0) == 1);
        end
    endtask

    task automatic apply_reset();
        tck   = 1'b0;
        rst_n = 1'b0;
        repeat (2) next_cycle();
        rst_n = 1'b1;
        model_reset();
    endtask

    task automatic wait_beat(output jtag_sniffer_pkg::digit_beat_t b);
        while (beat_q.size() == 0) begin
            next_cycle();
        end
        b = beat_q.pop_front();
    endtask

    function automatic logic [3:0] expected_nibble(input logic [1:0] row, input logic [3:0] col);
        case (row)
            2'd0: begin
                if (col == 4'd15) return model_state;
                if (col < 4'd4) return model_count[4 * col +: 4];
                return 4'h0;
            end
            2'd1: return model_tms[4 * col +: 4];
            2'd2: return model_tdi[4 * col +: 4];
            default: return model_tdo[4 * col +: 4];
        endcase
    endfunction

    // idle tck, then compare one whole frame taken after the idle
    task automatic check_frame(input string name);
        jtag_sniffer_pkg::digit_beat_t b;
        logic [3:0] want;
        tck = 1'b0;
        repeat (20) next_cycle();
        beat_q.delete();
        wait_beat(b);  // drop the beat loaded before the check
        do begin
            wait_beat(b);
        end while (b.row != 2'd0 || b.col != 4'd15);
        shown_state = b.nibble;
        for (int n = 0; n < 64; n++) begin
            if (n > 0) wait_beat(b);
            want = expected_nibble(b.row, b.col);
            if (b.nibble != want) begin
                value_errors++;
                $display("Error: %s row %0d col %0d expected %h actual %h",
                         name, b.row, b.col, want, b.nibble);
            end
        end
    endtask

    initial begin
        logic [8:0] seq;
        void'($urandom(10885));
        rst_n       = 1'b0;
        tck         = 1'b0;
        tms         = 1'b0;
        tdi         = 1'b0;
        tdo         = 1'b0;
        digit_ready = 1'b0;
        model_reset();
        repeat (2) next_cycle();
        rst_n = 1'b1;

        check_frame("reset frame");
        random_traffic(200);
        check_frame("tap tracking random");

        seq = 9'b1_1111_0100;  // five ones to reset, then into shift_dr
        for (int k = 8; k >= 0; k--) begin
            tck_period(seq[k], 1'b0, 1'b0);
        end
        check_frame("fixed tms sequence");
        if (shown_state != 4'h2) begin
            value_errors++;
            $display("Error: fixed tms sequence state expected 2 actual %h", shown_state);
        end

        random_traffic(100);
        check_frame("history and edge count");
        random_traffic(60);
        apply_reset();
        check_frame("mid-run reset");

        $display("value errors: %0d, handshake errors: %0d", value_errors, handshake_errors);
        if (value_errors + handshake_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
